// ==== bench/spring_scope_tb.sv ====
`timescale 1ns/1ps

module spring_scope_tb;
  import osc_pkg::*;

  localparam int STEP_DIV     = 8;
  localparam int DT_SHIFT     = 8;
  localparam int SCREEN_WIDTH = 64;
  localparam int TRACE1_BASE  = 120;
  localparam int TRACE2_BASE  = 360;
  localparam int Y_SHIFT      = 10;
  localparam int WATCHDOG_NS  = (SCREEN_WIDTH + 8) * STEP_DIV * 4 * 4;

  logic        AnalogClock;
  logic        reset;
  logic        psel, penable, pwrite;
  apb_addr_t   paddr;
  logic [31:0] pwdata, prdata;
  logic        pready, pslverr;
  sample_t     x1, x2;
  logic        pixel_valid;
  col_t        pixel_x;
  row_t        pixel_y;
  color_t      pixel_color;
  logic        sweep_done;

  integer  seed = 32'h2eea_9414;
  sample_t cfg_k1, cfg_k2, cfg_kmid, cfg_damp;
  sample_t cfg_x1, cfg_x2, cfg_v1, cfg_v2;
  sample_t m_x1, m_x2, m_v1, m_v2;  // golden model state
  logic    free_motion;             // every constant is zero
  logic    t1_seen;
  int      exp_col;
  col_t    t1_col;
  row_t    t1_row2;

  spring_scope_top #(
    .STEP_DIV (STEP_DIV), .DT_SHIFT (DT_SHIFT), .SCREEN_WIDTH (SCREEN_WIDTH),
    .TRACE1_BASE (TRACE1_BASE), .TRACE2_BASE (TRACE2_BASE), .Y_SHIFT (Y_SHIFT)
  ) uut (
    .AnalogClock (AnalogClock), .reset (reset),
    .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
    .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
    .x1 (x1), .x2 (x2),
    .pixel_valid (pixel_valid), .pixel_x (pixel_x), .pixel_y (pixel_y),
    .pixel_color (pixel_color), .sweep_done (sweep_done)
  );

  initial AnalogClock = 1'b0;
  always #2 AnalogClock = ~AnalogClock;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "run aborted");
  endtask

  task automatic report_mismatch(input string name, input longint got, input longint exp);
    abort_run($sformatf("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, exp));
  endtask

  // enters and leaves 1 ns after a rising edge
  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge AnalogClock);
    #1 penable = 1'b1;
    @(negedge AnalogClock);  // access phase settled
    rdata = prdata;
    err   = pslverr;
    @(posedge AnalogClock);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input logic [31:0] wdata, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, addr, wdata, rdata, err);
    assert (err == exp_err) else report_mismatch("pslverr", err, exp_err);
  endtask

  task automatic apb_read_check(input apb_addr_t addr, input logic [31:0] exp,
                                input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b0, addr, 32'h0, rdata, err);
    assert (err == exp_err) else report_mismatch("pslverr", err, exp_err);
    if (!exp_err)
      assert (rdata == exp) else report_mismatch($sformatf("prdata@%0h", addr), rdata, exp);
  endtask

  function automatic logic [31:0] sign_extend_low18(input logic [31:0] w);
    return {{14{w[17]}}, w[17:0]};
  endfunction

  // 2.16 product shifted back and wrapped to 18 bits
  function automatic sample_t fx_mul(input sample_t a, input sample_t b);
    longint p;
    p = (longint'(a) * longint'(b)) >>> 16;
    return sample_t'(p);
  endfunction

  function automatic row_t expected_row(input sample_t pos, input int base);
    longint r;
    r = base - (longint'(pos) >>> Y_SHIFT);
    if (r < 0)
      r = 0;
    else if (r > 511)
      r = 511;
    return row_t'(r);
  endfunction

  task automatic model_step();
    sample_t dx;
    longint  a1, a2;
    dx = m_x2 - m_x1;
    a1 = -longint'(fx_mul(cfg_k1, m_x1)) + longint'(fx_mul(cfg_kmid, dx))
         - longint'(fx_mul(cfg_damp, m_v1));
    a2 = -longint'(fx_mul(cfg_k2, m_x2)) - longint'(fx_mul(cfg_kmid, dx))
         - longint'(fx_mul(cfg_damp, m_v2));
    // positions use the velocities from before the step
    m_x1 = sample_t'(longint'(m_x1) + (longint'(m_v1) >>> DT_SHIFT));
    m_x2 = sample_t'(longint'(m_x2) + (longint'(m_v2) >>> DT_SHIFT));
    m_v1 = sample_t'(longint'(m_v1) + (a1 >>> DT_SHIFT));
    m_v2 = sample_t'(longint'(m_v2) + (a2 >>> DT_SHIFT));
  endtask

  // one trace 1 write means one finished step
  task automatic check_step();
    sample_t prev_x1, prev_x2, dx1, dx2;
    prev_x1 = m_x1;
    prev_x2 = m_x2;
    model_step();
    if (free_motion)
    begin
      // each step adds the initial velocity scaled by dt
      dx1 = x1 - prev_x1;
      dx2 = x2 - prev_x2;
      assert (dx1 == (cfg_v1 >>> DT_SHIFT))
        else report_mismatch("x1 step", dx1, cfg_v1 >>> DT_SHIFT);
      assert (dx2 == (cfg_v2 >>> DT_SHIFT))
        else report_mismatch("x2 step", dx2, cfg_v2 >>> DT_SHIFT);
    end
    else
    begin
      assert (x1 == m_x1) else report_mismatch("x1", x1, m_x1);
      assert (x2 == m_x2) else report_mismatch("x2", x2, m_x2);
    end
    assert (exp_col < SCREEN_WIDTH) else abort_run("more trace writes than screen columns");
    assert (pixel_x == exp_col) else report_mismatch("pixel_x", pixel_x, exp_col);
    assert (pixel_y == expected_row(m_x1, TRACE1_BASE))
      else report_mismatch("pixel_y", pixel_y, expected_row(m_x1, TRACE1_BASE));
    t1_col  = pixel_x;
    t1_row2 = expected_row(m_x2, TRACE2_BASE);
    exp_col++;
  endtask

  // pixel monitor at mid cycle
  always @(negedge AnalogClock)
  begin
    if (!reset)
    begin
      assert (!(sweep_done && pixel_valid)) else abort_run("pixel write after the sweep ended");
      if (t1_seen)
      begin
        assert (pixel_valid && pixel_color == 2'd2)
          else abort_run("trace 1 write not followed by a trace 2 write");
        assert (pixel_x == t1_col) else report_mismatch("pixel_x", pixel_x, t1_col);
        assert (pixel_y == t1_row2) else report_mismatch("pixel_y", pixel_y, t1_row2);
        t1_seen = 1'b0;
      end
      else if (pixel_valid)
      begin
        assert (pixel_color == 2'd1) else abort_run("trace 2 write without a trace 1 write");
        check_step();
        t1_seen = 1'b1;
      end
    end
  end

  a_pready_high: assert property (@(posedge AnalogClock) disable iff (reset) pready)
    else abort_run("pready went low");

  task automatic load_config();
    apb_write(REG_K1, 32'(cfg_k1), 1'b0);
    apb_write(REG_K2, 32'(cfg_k2), 1'b0);
    apb_write(REG_KMID, 32'(cfg_kmid), 1'b0);
    apb_write(REG_DAMP, 32'(cfg_damp), 1'b0);
    apb_write(REG_X1_INIT, 32'(cfg_x1), 1'b0);
    apb_write(REG_X2_INIT, 32'(cfg_x2), 1'b0);
    apb_write(REG_V1_INIT, 32'(cfg_v1), 1'b0);
    apb_write(REG_V2_INIT, 32'(cfg_v2), 1'b0);
    repeat (2) @(posedge AnalogClock);  // integrators load one cycle late
    @(negedge AnalogClock);
    assert (x1 == cfg_x1) else report_mismatch("x1 idle", x1, cfg_x1);
    assert (x2 == cfg_x2) else report_mismatch("x2 idle", x2, cfg_x2);
    @(posedge AnalogClock);
    #1;
  endtask

  task automatic start_run();
    m_x1    = cfg_x1;
    m_x2    = cfg_x2;
    m_v1    = cfg_v1;
    m_v2    = cfg_v2;
    exp_col = 0;
    apb_write(REG_CTRL, 32'h1, 1'b0);
  endtask

  task automatic finish_sweep();
    while (!sweep_done)
      @(negedge AnalogClock);
    @(posedge AnalogClock);
    #1;
    assert (exp_col == SCREEN_WIDTH) else report_mismatch("columns", exp_col, SCREEN_WIDTH);
    apb_read_check(REG_STATUS, 32'h1, 1'b0);
    repeat (2 * STEP_DIV) @(posedge AnalogClock);  // monitor watches for stray writes
    #1;
    apb_write(REG_CTRL, 32'h0, 1'b0);
    apb_read_check(REG_STATUS, 32'h0, 1'b0);
  endtask

  initial
  begin
    apb_addr_t   addrs[8];
    logic [31:0] wval;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    reset       = 1'b1;
    free_motion = 1'b0;
    t1_seen     = 1'b0;
    exp_col     = 0;
    repeat (3) @(posedge AnalogClock);
    #1 reset = 1'b0;

    // register readback and error responses
    addrs = '{REG_K1, REG_K2, REG_KMID, REG_DAMP,
              REG_X1_INIT, REG_X2_INIT, REG_V1_INIT, REG_V2_INIT};
    foreach (addrs[i])
    begin
      wval = $random(seed);
      apb_write(addrs[i], wval, 1'b0);
      apb_read_check(addrs[i], sign_extend_low18(wval), 1'b0);
    end
    apb_read_check(REG_CTRL, 32'h0, 1'b0);
    apb_write(REG_STATUS, 32'h1, 1'b1);
    apb_write(8'h28, 32'h5, 1'b1);
    apb_read_check(8'h02, 32'h0, 1'b1);

    // free motion with all constants zero
    free_motion = 1'b1;
    cfg_k1   = '0;
    cfg_k2   = '0;
    cfg_kmid = '0;
    cfg_damp = '0;
    cfg_x1   = sample_t'($random(seed));
    cfg_x2   = sample_t'($random(seed));
    cfg_v1   = sample_t'($random(seed) % 4096);
    cfg_v2   = sample_t'($random(seed) % 4096);
    load_config();
    start_run();
    finish_sweep();

    // coupled springs with damping over two sweeps
    free_motion = 1'b0;
    cfg_k1   = sample_t'($random(seed) & 32'h7ff);
    cfg_k2   = sample_t'($random(seed) & 32'h7ff);
    cfg_kmid = sample_t'($random(seed) & 32'h3ff);
    cfg_damp = sample_t'($random(seed) & 32'h1ff);
    cfg_x1   = sample_t'($random(seed));
    cfg_x2   = sample_t'($random(seed));
    cfg_v1   = sample_t'($random(seed) % 8192);
    cfg_v2   = sample_t'($random(seed) % 8192);
    load_config();
    start_run();
    finish_sweep();
    start_run();  // restart must begin again at column 0
    finish_sweep();

    $display("Everything OK");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    abort_run("watchdog timeout, the sweeps did not finish in time");
  end

endmodule

// ==== rtl/euler_integrator.sv ====
`timescale 1ns/1ps

module euler_integrator #(
  parameter int IN_WIDTH = 18,
  parameter int DT_SHIFT = 8
) (
  input  logic                        AnalogClock,
  input  logic                        reset,
  input  logic                        run,
  input  logic                        step_en,
  input  osc_pkg::sample_t            init_value,
  input  logic signed [IN_WIDTH-1:0]  rate,
  output osc_pkg::sample_t            state
);
  import osc_pkg::*;

  logic signed [IN_WIDTH-1:0] rate_dt;

  // dt as a power of two
  assign rate_dt = rate >>> DT_SHIFT;

  always_ff @(posedge AnalogClock)
  begin
    if (reset)
      state <= '0;
    else if (!run)
      state <= init_value;  // preload while idle
    else if (step_en)
      state <= state + sample_t'(rate_dt);  // wraps at 18 bits
  end

endmodule

// ==== rtl/osc_params_if.sv ====
`timescale 1ns/1ps

interface osc_params_if;
  import osc_pkg::*;

  sample_t k1;       // left spring
  sample_t k2;       // right spring
  sample_t kmid;     // coupling spring
  sample_t damp;
  sample_t x1_init;
  sample_t x2_init;
  sample_t v1_init;
  sample_t v2_init;
  logic    run;

  // register block drives everything
  modport cfg (output k1, k2, kmid, damp, x1_init, x2_init, v1_init, v2_init, run);

  modport core (input k1, k2, kmid, damp, x1_init, x2_init, v1_init, v2_init, run);

  // plotter only needs the run bit
  modport plot (input run);

endinterface

// ==== rtl/osc_pkg.sv ====
package osc_pkg;

  // 2.16 fixed point, used for positions, velocities and constants
  typedef logic signed [17:0] sample_t;

  // acceleration sum, three extra bits of headroom
  typedef logic signed [20:0] accel_t;

  typedef logic [9:0] col_t;       // screen column
  typedef logic [8:0] row_t;       // screen row
  typedef logic [1:0] color_t;     // 1 = trace 1, 2 = trace 2
  typedef logic [7:0] apb_addr_t;  // APB byte address

  // register map
  localparam apb_addr_t REG_CTRL    = 8'h00;
  localparam apb_addr_t REG_K1      = 8'h04;
  localparam apb_addr_t REG_K2      = 8'h08;
  localparam apb_addr_t REG_KMID    = 8'h0C;
  localparam apb_addr_t REG_DAMP    = 8'h10;
  localparam apb_addr_t REG_X1_INIT = 8'h14;
  localparam apb_addr_t REG_X2_INIT = 8'h18;
  localparam apb_addr_t REG_V1_INIT = 8'h1C;
  localparam apb_addr_t REG_V2_INIT = 8'h20;
  localparam apb_addr_t REG_STATUS  = 8'h24;  // read only

  // plotter sequencing
  typedef enum logic [1:0] {
    PLOT_WAIT,    // waiting for the next step
    PLOT_TRACE1,  // writing trace 1 pixel
    PLOT_TRACE2,  // writing trace 2 pixel
    PLOT_DONE     // sweep finished, no more writes
  } plot_state_t;

endpackage

// ==== rtl/osc_regs.sv ====
`timescale 1ns/1ps

module osc_regs (
  input  logic                AnalogClock,
  input  logic                reset,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  osc_pkg::apb_addr_t  paddr,
  input  logic [31:0]         pwdata,
  output logic [31:0]         prdata,
  output logic                pready,
  output logic                pslverr,
  input  logic                sweep_done,
  osc_params_if.cfg           cfg
);
  import osc_pkg::*;

  sample_t k1_q, k2_q, kmid_q, damp_q;
  sample_t x1_init_q, x2_init_q, v1_init_q, v2_init_q;
  logic    run_q;
  logic    access;
  logic    addr_hit;
  logic    wr_en;

  function automatic logic [31:0] sext(input sample_t v);
    return {{14{v[17]}}, v};
  endfunction

  assign pready = 1'b1;  // zero wait states
  assign access = psel && penable;
  assign wr_en  = access && pwrite && !pslverr;

  // writing the read-only status is an error
  assign pslverr = access && (!addr_hit || (pwrite && paddr == REG_STATUS));

  always_ff @(posedge AnalogClock)
  begin
    if (reset)
    begin
      run_q     <= 1'b0;
      k1_q      <= '0;
      k2_q      <= '0;
      kmid_q    <= '0;
      damp_q    <= '0;
      x1_init_q <= '0;
      x2_init_q <= '0;
      v1_init_q <= '0;
      v2_init_q <= '0;
    end
    else if (wr_en)
    begin
      case (paddr)
        REG_CTRL:    run_q     <= pwdata[0];
        REG_K1:      k1_q      <= pwdata[17:0];
        REG_K2:      k2_q      <= pwdata[17:0];
        REG_KMID:    kmid_q    <= pwdata[17:0];
        REG_DAMP:    damp_q    <= pwdata[17:0];
        REG_X1_INIT: x1_init_q <= pwdata[17:0];
        REG_X2_INIT: x2_init_q <= pwdata[17:0];
        REG_V1_INIT: v1_init_q <= pwdata[17:0];
        REG_V2_INIT: v2_init_q <= pwdata[17:0];
        default: ;
      endcase
    end
  end

  // read mux flags unmapped addresses too
  always_comb
  begin
    prdata   = '0;
    addr_hit = 1'b1;
    case (paddr)
      REG_CTRL:    prdata = {31'd0, run_q};
      REG_K1:      prdata = sext(k1_q);
      REG_K2:      prdata = sext(k2_q);
      REG_KMID:    prdata = sext(kmid_q);
      REG_DAMP:    prdata = sext(damp_q);
      REG_X1_INIT: prdata = sext(x1_init_q);
      REG_X2_INIT: prdata = sext(x2_init_q);
      REG_V1_INIT: prdata = sext(v1_init_q);
      REG_V2_INIT: prdata = sext(v2_init_q);
      REG_STATUS:  prdata = {31'd0, sweep_done};
      default:     addr_hit = 1'b0;
    endcase
  end

  assign cfg.run     = run_q;
  assign cfg.k1      = k1_q;
  assign cfg.k2      = k2_q;
  assign cfg.kmid    = kmid_q;
  assign cfg.damp    = damp_q;
  assign cfg.x1_init = x1_init_q;
  assign cfg.x2_init = x2_init_q;
  assign cfg.v1_init = v1_init_q;
  assign cfg.v2_init = v2_init_q;

endmodule

// ==== rtl/spring_core.sv ====
`timescale 1ns/1ps

module spring_core #(
  parameter int STEP_DIV = 32,
  parameter int DT_SHIFT = 8
) (
  input  logic              AnalogClock,
  input  logic              reset,
  osc_params_if.core        params,
  output osc_pkg::sample_t  x1,
  output osc_pkg::sample_t  x2,
  output logic              step_done
);
  import osc_pkg::*;

  localparam int CNT_W = $clog2(STEP_DIV);

  logic [CNT_W-1:0] div_cnt;
  logic             step_en;

  sample_t v1, v2;
  sample_t dx;                       // x2 - x1, wraps
  sample_t k1_x1, k2_x2, kmid_dx;
  sample_t damp_v1, damp_v2;
  accel_t  a1, a2;

  // 18x18 product back into 2.16
  function automatic sample_t scaled(input sample_t a, input sample_t b);
    logic signed [35:0] prod;
    prod = a * b;
    return prod[33:16];
  endfunction

  // step divider, parked at zero while stopped
  always_ff @(posedge AnalogClock)
  begin
    if (reset || !params.run)
      div_cnt <= '0;
    else if (div_cnt == CNT_W'(STEP_DIV - 1))
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  assign step_en = params.run && (div_cnt == CNT_W'(STEP_DIV - 1));

  always_ff @(posedge AnalogClock)
  begin
    if (reset)
      step_done <= 1'b0;
    else
      step_done <= step_en;  // state updated on this edge
  end

  assign dx      = x2 - x1;
  assign k1_x1   = scaled(params.k1, x1);
  assign k2_x2   = scaled(params.k2, x2);
  assign kmid_dx = scaled(params.kmid, dx);
  assign damp_v1 = scaled(params.damp, v1);
  assign damp_v2 = scaled(params.damp, v2);

  // coupling spring pulls the masses toward each other
  assign a1 = -accel_t'(k1_x1) + accel_t'(kmid_dx) - accel_t'(damp_v1);
  assign a2 = -accel_t'(k2_x2) - accel_t'(kmid_dx) - accel_t'(damp_v2);

  euler_integrator #(.IN_WIDTH($bits(accel_t)), .DT_SHIFT(DT_SHIFT)) v1_int (
    .AnalogClock (AnalogClock),
    .reset       (reset),
    .run         (params.run),
    .step_en     (step_en),
    .init_value  (params.v1_init),
    .rate        (a1),
    .state       (v1)
  );

  euler_integrator #(.IN_WIDTH($bits(sample_t)), .DT_SHIFT(DT_SHIFT)) x1_int (
    .AnalogClock (AnalogClock),
    .reset       (reset),
    .run         (params.run),
    .step_en     (step_en),
    .init_value  (params.x1_init),
    .rate        (v1),
    .state       (x1)
  );

  euler_integrator #(.IN_WIDTH($bits(accel_t)), .DT_SHIFT(DT_SHIFT)) v2_int (
    .AnalogClock (AnalogClock),
    .reset       (reset),
    .run         (params.run),
    .step_en     (step_en),
    .init_value  (params.v2_init),
    .rate        (a2),
    .state       (v2)
  );

  euler_integrator #(.IN_WIDTH($bits(sample_t)), .DT_SHIFT(DT_SHIFT)) x2_int (
    .AnalogClock (AnalogClock),
    .reset       (reset),
    .run         (params.run),
    .step_en     (step_en),
    .init_value  (params.x2_init),
    .rate        (v2),
    .state       (x2)
  );

  a_single_step_done: assert property (@(posedge AnalogClock) disable iff (reset)
    step_done |=> !step_done)
    else $error("step_done held for two cycles");

endmodule

// ==== rtl/spring_scope_top.sv ====
`timescale 1ns/1ps

module spring_scope_top #(
  parameter int STEP_DIV     = 32,
  parameter int DT_SHIFT     = 8,
  parameter int SCREEN_WIDTH = 640,
  parameter int TRACE1_BASE  = 120,
  parameter int TRACE2_BASE  = 360,
  parameter int Y_SHIFT      = 10
) (
  input  logic                AnalogClock,
  input  logic                reset,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  osc_pkg::apb_addr_t  paddr,
  input  logic [31:0]         pwdata,
  output logic [31:0]         prdata,
  output logic                pready,
  output logic                pslverr,
  output osc_pkg::sample_t    x1,
  output osc_pkg::sample_t    x2,
  output logic                pixel_valid,
  output osc_pkg::col_t       pixel_x,
  output osc_pkg::row_t       pixel_y,
  output osc_pkg::color_t     pixel_color,
  output logic                sweep_done
);

  logic step_done;

  osc_params_if params_if ();

  osc_regs regs (
    .AnalogClock (AnalogClock),
    .reset       (reset),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .sweep_done  (sweep_done),
    .cfg         (params_if.cfg)
  );

  spring_core #(.STEP_DIV(STEP_DIV), .DT_SHIFT(DT_SHIFT)) core (
    .AnalogClock (AnalogClock),
    .reset       (reset),
    .params      (params_if.core),
    .x1          (x1),
    .x2          (x2),
    .step_done   (step_done)
  );

  trace_plotter #(
    .SCREEN_WIDTH (SCREEN_WIDTH),
    .TRACE1_BASE  (TRACE1_BASE),
    .TRACE2_BASE  (TRACE2_BASE),
    .Y_SHIFT      (Y_SHIFT)
  ) plotter (
    .AnalogClock (AnalogClock),
    .reset       (reset),
    .step_done   (step_done),
    .params      (params_if.plot),
    .x1          (x1),
    .x2          (x2),
    .pixel_valid (pixel_valid),
    .pixel_x     (pixel_x),
    .pixel_y     (pixel_y),
    .pixel_color (pixel_color),
    .sweep_done  (sweep_done)
  );

endmodule

// ==== rtl/trace_plotter.sv ====
`timescale 1ns/1ps

module trace_plotter #(
  parameter int SCREEN_WIDTH = 640,
  parameter int TRACE1_BASE  = 120,
  parameter int TRACE2_BASE  = 360,
  parameter int Y_SHIFT      = 10
) (
  input  logic              AnalogClock,
  input  logic              reset,
  input  logic              step_done,
  osc_params_if.plot        params,
  input  osc_pkg::sample_t  x1,
  input  osc_pkg::sample_t  x2,
  output logic              pixel_valid,
  output osc_pkg::col_t     pixel_x,
  output osc_pkg::row_t     pixel_y,
  output osc_pkg::color_t   pixel_color,
  output logic              sweep_done
);
  import osc_pkg::*;

  plot_state_t state;
  col_t        col;
  row_t        row1_q, row2_q;

  // positive displacement moves the trace up the screen
  function automatic row_t to_row(input sample_t pos, input int base);
    int r;
    r = base - (int'(pos) >>> Y_SHIFT);
    if (r < 0)
      return '0;
    else if (r > 511)
      return row_t'(511);
    else
      return row_t'(r);
  endfunction

  always_ff @(posedge AnalogClock)
  begin
    if (reset || !params.run)
    begin
      state <= PLOT_WAIT;
      col   <= '0;
    end
    else
    begin
      case (state)
        PLOT_WAIT:   if (step_done) state <= PLOT_TRACE1;
        PLOT_TRACE1: state <= PLOT_TRACE2;
        PLOT_TRACE2:
        begin
          col   <= col + 1'b1;
          state <= (col == col_t'(SCREEN_WIDTH - 1)) ? PLOT_DONE : PLOT_WAIT;
        end
        default: ;  // PLOT_DONE holds until run drops
      endcase
    end
  end

  // rows sampled with the fresh positions
  always_ff @(posedge AnalogClock)
  begin
    if (state == PLOT_WAIT && step_done)
    begin
      row1_q <= to_row(x1, TRACE1_BASE);
      row2_q <= to_row(x2, TRACE2_BASE);
    end
  end

  assign pixel_valid = (state == PLOT_TRACE1) || (state == PLOT_TRACE2);
  assign pixel_x     = col;
  assign pixel_y     = (state == PLOT_TRACE1) ? row1_q : row2_q;
  assign pixel_color = (state == PLOT_TRACE1) ? color_t'(1) : color_t'(2);
  assign sweep_done  = (state == PLOT_DONE);

  a_col_on_screen: assert property (@(posedge AnalogClock) disable iff (reset)
    pixel_valid |-> (pixel_x < SCREEN_WIDTH))
    else $error("pixel column off screen");

endmodule

// ==== sim.f ====
rtl/osc_pkg.sv
rtl/osc_params_if.sv
rtl/osc_regs.sv
rtl/euler_integrator.sv
rtl/spring_core.sv
rtl/trace_plotter.sv
rtl/spring_scope_top.sv
bench/spring_scope_tb.sv
